// File: design/scc_regs_pkg.sv
//----------------------------
// Register map, data word and control and status types of the sync block
// Imported by the register decoder, the sync engine and the top level
//----------------------------
package scc_regs_pkg;

    // Register word and byte address widths
    localparam int reg_data_w = 32;
    localparam int reg_addr_w = 8;

    typedef logic [reg_data_w-1:0] reg_data_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // Byte offsets within the bank
    typedef enum reg_addr_t {
        SR        = 8'h00,
        CR        = 8'h04,
        CR_S      = 8'h08,
        CR_C      = 8'h0C,
        SYNC_EV   = 8'h10,
        SYNC_PRD  = 8'h14,
        ALIGN_EV0 = 8'h18,
        ALIGN_EV1 = 8'h1C,
        ALIGN_EV2 = 8'h20,
        ALIGN_EV3 = 8'h24,
        TEST0_EV  = 8'h28,
        TEST1_EV  = 8'h2C,
        TEST2_EV  = 8'h30,
        TEST3_EV  = 8'h34
    } reg_addr_e;

    // Control register, bit 0 is dds_clk_ena
    typedef struct packed {
        logic clk_sync_manual;
        logic dds_sync_ena;
        logic dds_clk_ena;
    } cr_t;

    // Status register
    // Upper four bits are sticky, lower three are live
    typedef struct packed {
        logic odd_shift;
        logic dc_changed;
        logic afe_down;
        logic clk_sync_loss;
        logic clk_sync_done;
        logic dds_sync_ena;
        logic dds_clk_ena;
    } sr_t;

endpackage

// File: design/scc_event_pkg.sv
//----------------------------
// Timing event code and the event configuration and hit types
//----------------------------
package scc_event_pkg;

    localparam int event_w  = 8;
    // Align channels, and the same number of test channels
    localparam int ev_chans = 4;

    // Code 0 means no event
    typedef logic [event_w-1:0] event_t;

    typedef struct packed {
        event_t                  sync_code;
        event_t [ev_chans-1:0]   align_code;
        event_t [ev_chans-1:0]   test_code;
    } event_cfg_t;

    typedef struct packed {
        logic                    sync_hit;
        logic [ev_chans-1:0]     align_hit;
        logic [ev_chans-1:0]     test_hit;
    } event_hits_t;

endpackage

// File: design/scc_reg_decode.sv
//----------------------------
// Register bank with strobe access and one-cycle read latency
// Holds control, event codes and the sticky status flags
//----------------------------
`timescale 1ns/100ps

module scc_reg_decode #(
    parameter int sync_prd_def = 64
) (
    input  logic                      clk,
    input  logic                      aresetn,
    input  logic                      reg_wr,
    input  logic                      reg_rd,
    input  scc_regs_pkg::reg_addr_t   reg_addr,
    input  scc_regs_pkg::reg_data_t   reg_wdata,
    output scc_regs_pkg::reg_data_t   reg_rdata,
    output logic                      reg_rvalid,
    input  logic                      dds_clk_ena_int,
    input  logic                      dds_sync_ena_int,
    input  logic                      sync_done,
    input  logic                      odd_shift_p,
    input  logic                      afe_init_done,
    input  logic                      dc_coarse_done,
    output scc_regs_pkg::cr_t         cr,
    output scc_regs_pkg::reg_data_t   sync_prd,
    output scc_event_pkg::event_cfg_t cfg,
    output logic                      llrf_sync_done
);
    import scc_regs_pkg::*;
    import scc_event_pkg::*;

    sr_t       sr;
    sr_t       wr_sr;
    cr_t       wr_cr;
    event_t    wr_code;
    reg_data_t rd_mux;

    // Sticky flags
    logic      odd_shift_f;
    logic      dc_changed_f;
    logic      afe_down_f;
    logic      sync_loss_f;

    // Previous levels for falling edge detection
    logic      afe_q;
    logic      dc_q;
    logic      done_q;

    assign wr_sr   = sr_t'(reg_wdata[$bits(sr_t)-1:0]);
    assign wr_cr   = cr_t'(reg_wdata[$bits(cr_t)-1:0]);
    assign wr_code = reg_wdata[$bits(event_t)-1:0];

    //----------------------------
    // Configuration writes
    //----------------------------
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            cr       <= '0;
            sync_prd <= reg_data_t'(sync_prd_def);
            cfg      <= '0;
        end else if (reg_wr) begin
            case (reg_addr)
                CR:       cr <= wr_cr;
                CR_S:     cr <= cr | wr_cr;
                CR_C:     cr <= cr & ~wr_cr;
                SYNC_EV:  cfg.sync_code <= wr_code;
                SYNC_PRD: begin
                    // A zero period would stall the counter
                    if (reg_wdata != '0) begin
                        sync_prd <= reg_wdata;
                    end
                end
                default: ;
            endcase
            for (int i = 0; i < ev_chans; i++) begin
                if (reg_addr == reg_addr_t'(ALIGN_EV0 + 4 * i)) begin
                    cfg.align_code[i] <= wr_code;
                end
                if (reg_addr == reg_addr_t'(TEST0_EV + 4 * i)) begin
                    cfg.test_code[i] <= wr_code;
                end
            end
        end
    end

    //----------------------------
    // Read path
    //----------------------------
    always_comb begin
        rd_mux = '0;
        case (reg_addr)
            SR:             rd_mux = reg_data_t'(sr);
            CR, CR_S, CR_C: rd_mux = reg_data_t'(cr);
            SYNC_EV:        rd_mux = reg_data_t'(cfg.sync_code);
            SYNC_PRD:       rd_mux = sync_prd;
            default: ;
        endcase
        for (int i = 0; i < ev_chans; i++) begin
            if (reg_addr == reg_addr_t'(ALIGN_EV0 + 4 * i)) begin
                rd_mux = reg_data_t'(cfg.align_code[i]);
            end
            if (reg_addr == reg_addr_t'(TEST0_EV + 4 * i)) begin
                rd_mux = reg_data_t'(cfg.test_code[i]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            reg_rvalid <= 1'b0;
        end else begin
            reg_rvalid <= reg_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (reg_rd) begin
            reg_rdata <= rd_mux;
        end
    end

    //----------------------------
    // Sticky status
    //----------------------------
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            afe_q        <= 1'b0;
            dc_q         <= 1'b0;
            done_q       <= 1'b0;
            odd_shift_f  <= 1'b0;
            dc_changed_f <= 1'b0;
            afe_down_f   <= 1'b0;
            sync_loss_f  <= 1'b0;
        end else begin
            afe_q  <= afe_init_done;
            dc_q   <= dc_coarse_done;
            done_q <= sync_done;
            // Zero bits clear, ones keep
            if (reg_wr && reg_addr == SR) begin
                odd_shift_f  <= odd_shift_f & wr_sr.odd_shift;
                dc_changed_f <= dc_changed_f & wr_sr.dc_changed;
                afe_down_f   <= afe_down_f & wr_sr.afe_down;
                sync_loss_f  <= sync_loss_f & wr_sr.clk_sync_loss;
            end
            // New events win over a clear in the same cycle
            if (afe_q && !afe_init_done) begin
                afe_down_f <= 1'b1;
            end
            if (dc_q && !dc_coarse_done) begin
                dc_changed_f <= 1'b1;
            end
            if (done_q && !sync_done) begin
                sync_loss_f <= 1'b1;
            end
            if (odd_shift_p) begin
                odd_shift_f <= 1'b1;
                sync_loss_f <= 1'b1;
            end
        end
    end

    // Live bits, manual mode shows the CR enables
    always_comb begin
        sr.odd_shift     = odd_shift_f;
        sr.dc_changed    = dc_changed_f;
        sr.afe_down      = afe_down_f;
        sr.clk_sync_loss = sync_loss_f;
        sr.clk_sync_done = sync_done;
        sr.dds_sync_ena  = cr.clk_sync_manual ? cr.dds_sync_ena : dds_sync_ena_int;
        sr.dds_clk_ena   = cr.clk_sync_manual ? cr.dds_clk_ena : dds_clk_ena_int;
    end

    assign llrf_sync_done = sr.clk_sync_done;

    // Bus master issues one access per cycle
    a_no_rd_wr: assert property (@(posedge clk) disable iff (!aresetn)
        !(reg_wr && reg_rd));

endmodule

// File: design/scc_event_match.sv
//----------------------------
// Compares the incoming event code with the configured sync, align and test codes
//----------------------------
`timescale 1ns/100ps

module scc_event_match (
    input  scc_event_pkg::event_t      ev,
    input  scc_event_pkg::event_cfg_t  cfg,
    output scc_event_pkg::event_hits_t hits
);
    import scc_event_pkg::*;

    // Unconfigured slots hold 0 and never match
    function automatic logic code_hit(input event_t code, input event_t ev_in);
        return code != '0 && code == ev_in;
    endfunction

    always_comb begin
        hits.sync_hit = code_hit(cfg.sync_code, ev);
        for (int i = 0; i < ev_chans; i++) begin
            hits.align_hit[i] = code_hit(cfg.align_code[i], ev);
            hits.test_hit[i]  = code_hit(cfg.test_code[i], ev);
        end
    end

endmodule

// File: design/scc_sync_engine.sv
//----------------------------
// Sync period counter, DDS clock divider and automatic start-up sequencer
//----------------------------
`timescale 1ns/100ps

module scc_sync_engine (
    input  logic                       clk,
    input  logic                       aresetn,
    input  scc_event_pkg::event_hits_t hits,
    input  scc_regs_pkg::cr_t          cr,
    input  scc_regs_pkg::reg_data_t    sync_prd,
    input  logic                       evr_link_ok,
    input  logic                       afe_init_done,
    input  logic                       dc_coarse_done,
    output logic                       sync_strobe,
    output logic                       dds_clk,
    output logic                       dds_clk_ena_int,
    output logic                       dds_sync_ena_int,
    output logic                       sync_done,
    output logic                       odd_shift_p
);
    import scc_regs_pkg::*;

    typedef enum logic [2:0] {
        idle,
        wait_ready,
        clk_on,
        sync_on,
        done
    } seq_state_e;

    seq_state_e state;
    seq_state_e state_nxt;
    reg_data_t  cnt;
    logic       sync_ena;
    logic       auto_mode;
    logic       ready;

    assign auto_mode = !cr.clk_sync_manual;
    assign ready     = evr_link_ok && afe_init_done && dc_coarse_done;
    assign sync_ena  = auto_mode ? dds_sync_ena_int : cr.dds_sync_ena;

    //----------------------------
    // Period counter
    //----------------------------
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            cnt <= sync_prd - 1'b1;
        end else if (cnt >= sync_prd) begin
            // Period was shortened under the counter
            cnt <= sync_prd - 1'b1;
        end else if (sync_ena) begin
            if (cnt == '0 || hits.sync_hit) begin
                cnt <= sync_prd - 1'b1;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    assign sync_strobe = sync_ena && cnt == '0;

    //----------------------------
    // DDS clock divider
    //----------------------------
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            dds_clk <= 1'b0;
        end else if (hits.sync_hit) begin
            dds_clk <= 1'b0;
        end else begin
            dds_clk <= ~dds_clk;
        end
    end

    // Sync event landing on the wrong divider phase
    assign odd_shift_p = sync_done && hits.sync_hit && !dds_clk;

    //----------------------------
    // Start-up sequencer
    //----------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            idle:       state_nxt = auto_mode ? wait_ready : idle;
            wait_ready: state_nxt = ready ? clk_on : wait_ready;
            clk_on:     state_nxt = sync_on;
            sync_on:    state_nxt = hits.sync_hit ? done : sync_on;
            default: ;
        endcase
        // Manual mode or a lost ready input restarts the bring-up
        if (!auto_mode || (dds_clk_ena_int && !ready)) begin
            state_nxt = idle;
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            state <= idle;
        end else begin
            state <= state_nxt;
        end
    end

    assign dds_clk_ena_int  = state inside {clk_on, sync_on, done};
    assign dds_sync_ena_int = state inside {sync_on, done};
    assign sync_done        = state == done;

    // Holds once the period register has settled
    a_cnt_range: assert property (@(posedge clk) disable iff (!aresetn)
        $stable(sync_prd) |-> cnt <= sync_prd - 1'b1);

endmodule

// File: design/scc_pulse_out.sv
//----------------------------
// Forms the sync pulse, stretches the x2 and test pulses and gates the DDS clock
//----------------------------
`timescale 1ns/100ps

module scc_pulse_out #(
    parameter int pulse_width = 2
) (
    input  logic                               clk,
    input  logic                               aresetn,
    input  logic                               sync_strobe,
    input  scc_event_pkg::event_hits_t         hits,
    input  logic                               dds_clk,
    input  logic                               dds_clk_ena,
    output logic                               sync,
    output logic                               sync_x2,
    output logic                               align_x2,
    output logic [scc_event_pkg::ev_chans-1:0] test_out,
    output logic                               dds_clk_out
);
    import scc_event_pkg::*;

    // Channel order: sync_x2, align_x2, then the test channels
    localparam int n_str = ev_chans + 2;
    localparam int cnt_w = $clog2(pulse_width + 1);

    typedef logic [cnt_w-1:0] width_cnt_t;

    logic [n_str-1:0] trig;
    logic [n_str-1:0] str_out;
    width_cnt_t       str_cnt [n_str];

    assign trig = {hits.test_hit, |hits.align_hit, sync_strobe};

    // Retrigger restarts the full width
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            str_cnt <= '{default: '0};
        end else begin
            for (int i = 0; i < n_str; i++) begin
                if (trig[i]) begin
                    str_cnt[i] <= width_cnt_t'(pulse_width);
                end else if (str_cnt[i] != '0) begin
                    str_cnt[i] <= str_cnt[i] - 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < n_str; i++) begin
            str_out[i] = str_cnt[i] != '0;
        end
    end

    assign sync_x2  = str_out[0];
    assign align_x2 = str_out[1];
    assign test_out = str_out[n_str-1:2];

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            sync        <= 1'b0;
            dds_clk_out <= 1'b0;
        end else begin
            sync        <= sync_strobe;
            dds_clk_out <= dds_clk_ena && dds_clk;
        end
    end

endmodule

// File: design/scc_top.sv
//----------------------------
// Sync and clock control top level
// Wires registers, event matcher, sync engine and pulse stage
//----------------------------
`timescale 1ns/100ps

module scc_top #(
    parameter int sync_prd_def = 64,
    parameter int pulse_width  = 2
) (
    input  logic                               clk,
    input  logic                               aresetn,
    input  logic                               reg_wr,
    input  logic                               reg_rd,
    input  scc_regs_pkg::reg_addr_t            reg_addr,
    input  scc_regs_pkg::reg_data_t            reg_wdata,
    output scc_regs_pkg::reg_data_t            reg_rdata,
    output logic                               reg_rvalid,
    input  scc_event_pkg::event_t              ev,
    input  logic                               afe_init_done,
    input  logic                               evr_link_ok,
    input  logic                               dc_coarse_done,
    output logic                               llrf_sync_done,
    output logic                               sync,
    output logic                               sync_x2,
    output logic                               align_x2,
    output logic [scc_event_pkg::ev_chans-1:0] test_out,
    output logic                               dds_clk_out
);
    import scc_regs_pkg::*;
    import scc_event_pkg::*;

    cr_t         cr;
    reg_data_t   sync_prd;
    event_cfg_t  cfg;
    event_hits_t hits;
    logic        sync_strobe;
    logic        dds_clk;
    logic        dds_clk_ena_int;
    logic        dds_sync_ena_int;
    logic        dds_clk_ena;
    logic        sync_done;
    logic        odd_shift_p;

    // Output clock gate follows CR in manual mode
    assign dds_clk_ena = cr.clk_sync_manual ? cr.dds_clk_ena : dds_clk_ena_int;

    scc_reg_decode #(
        .sync_prd_def(sync_prd_def)
    ) reg_decode_i (
        .clk              (clk),
        .aresetn          (aresetn),
        .reg_wr           (reg_wr),
        .reg_rd           (reg_rd),
        .reg_addr         (reg_addr),
        .reg_wdata        (reg_wdata),
        .reg_rdata        (reg_rdata),
        .reg_rvalid       (reg_rvalid),
        .dds_clk_ena_int  (dds_clk_ena_int),
        .dds_sync_ena_int (dds_sync_ena_int),
        .sync_done        (sync_done),
        .odd_shift_p      (odd_shift_p),
        .afe_init_done    (afe_init_done),
        .dc_coarse_done   (dc_coarse_done),
        .cr               (cr),
        .sync_prd         (sync_prd),
        .cfg              (cfg),
        .llrf_sync_done   (llrf_sync_done)
    );

    scc_event_match event_match_i (
        .ev   (ev),
        .cfg  (cfg),
        .hits (hits)
    );

    scc_sync_engine sync_engine_i (
        .clk              (clk),
        .aresetn          (aresetn),
        .hits             (hits),
        .cr               (cr),
        .sync_prd         (sync_prd),
        .evr_link_ok      (evr_link_ok),
        .afe_init_done    (afe_init_done),
        .dc_coarse_done   (dc_coarse_done),
        .sync_strobe      (sync_strobe),
        .dds_clk          (dds_clk),
        .dds_clk_ena_int  (dds_clk_ena_int),
        .dds_sync_ena_int (dds_sync_ena_int),
        .sync_done        (sync_done),
        .odd_shift_p      (odd_shift_p)
    );

    scc_pulse_out #(
        .pulse_width(pulse_width)
    ) pulse_out_i (
        .clk         (clk),
        .aresetn     (aresetn),
        .sync_strobe (sync_strobe),
        .hits        (hits),
        .dds_clk     (dds_clk),
        .dds_clk_ena (dds_clk_ena),
        .sync        (sync),
        .sync_x2     (sync_x2),
        .align_x2    (align_x2),
        .test_out    (test_out),
        .dds_clk_out (dds_clk_out)
    );

endmodule

// File: test/scc_checker.sv
//----------------------------
// Checks the sync block ports for each test line issued by the testbench
// Prints one line per test and the totals when the run is over
//----------------------------
`timescale 1ns/100ps

module scc_checker #(
    parameter int pulse_width = 2
) (
    input  logic                               clk,
    input  logic                               go,
    input  logic [3:0]                         op,
    input  logic [7:0]                         sel,
    input  logic [31:0]                        data,
    input  logic [31:0]                        expv,
    input  logic                               all_done,
    input  logic                               reg_rvalid,
    input  logic [31:0]                        reg_rdata,
    input  logic                               llrf_sync_done,
    input  logic                               sync,
    input  logic                               sync_x2,
    input  logic                               align_x2,
    input  logic [scc_event_pkg::ev_chans-1:0] test_out,
    input  logic                               dds_clk_out,
    output logic                               busy,
    output int                                 err_cnt
);
    import scc_event_pkg::*;

    localparam logic [3:0] op_write  = 4'd1;
    localparam logic [3:0] op_read   = 4'd2;
    localparam logic [3:0] op_event  = 4'd3;
    localparam logic [3:0] op_level  = 4'd4;
    localparam logic [3:0] op_period = 4'd5;
    localparam logic [3:0] op_wait   = 4'd6;
    // align_x2 plus the test channels
    localparam int n_out      = ev_chans + 1;
    localparam int wait_limit = 100;
    // Even number of samples of the DDS clock output
    localparam int clk_window = 4;

    logic busy_q = 1'b0;
    int   errors = 0;
    int   checks = 0;
    int   tests  = 0;
    bit   test_ok;

    assign busy    = busy_q;
    assign err_cnt = errors;

    function automatic string op_name(input logic [3:0] code);
        case (code)
            op_write:  return "write";
            op_read:   return "read";
            op_event:  return "event";
            op_level:  return "level";
            op_period: return "period";
            op_wait:   return "wait";
            default:   return "idle";
        endcase
    endfunction

    task automatic check_eq(input string sig, input logic [31:0] want, input logic [31:0] got);
        checks++;
        if (want !== got) begin
            $display("Error at time %0t: %s expected 0x%0h got 0x%0h", $time, sig, want, got);
            errors++;
            test_ok = 1'b0;
        end
    endtask

    task automatic flag_failure(input string what);
        checks++;
        errors++;
        test_ok = 1'b0;
        $display("Failure at time %0t: %s", $time, what);
    endtask

    // Data is due on the edge after the one that takes reg_rd
    task automatic check_read(input logic [31:0] want);
        @(posedge clk);
        if (reg_rvalid !== 1'b1) begin
            flag_failure("reg_rvalid was not high one cycle after reg_rd");
        end else begin
            check_eq("reg_rdata", want, reg_rdata);
        end
    endtask

    // Mask bit 0 is align_x2, bits above it are test_out
    task automatic check_event(input logic [31:0] mask);
        int               width [n_out];
        logic [n_out-1:0] seen;
        for (int b = 0; b < n_out; b++) begin
            width[b] = 0;
        end
        repeat (pulse_width + 2) begin
            @(posedge clk);
            seen = {test_out, align_x2};
            for (int b = 0; b < n_out; b++) begin
                if (seen[b]) begin
                    width[b]++;
                end
            end
        end
        check_eq("align_x2 width", mask[0] ? pulse_width : 0, width[0]);
        for (int b = 1; b < n_out; b++) begin
            check_eq($sformatf("test_out[%0d] width", b - 1),
                     mask[b] ? pulse_width : 0, width[b]);
        end
    endtask

    task automatic check_period(input int prd, input int n_gaps);
        int last;
        int run;
        int x2run;
        int gaps;
        int x2_pulses;
        last      = -1;
        run       = 0;
        x2run     = 0;
        gaps      = 0;
        x2_pulses = 0;
        for (int k = 0; k < (n_gaps + 1) * prd + 2; k++) begin
            @(posedge clk);
            if (sync) begin
                run++;
                if (run == 1) begin
                    if (last >= 0) begin
                        check_eq("sync period", prd, k - last);
                        gaps++;
                    end
                    last = k;
                end
            end else begin
                if (run > 0) begin
                    check_eq("sync width", 1, run);
                end
                run = 0;
            end
            if (sync_x2) begin
                x2run++;
            end else begin
                // A pulse cut off by the window end is not judged
                if (x2run > 0) begin
                    check_eq("sync_x2 width", pulse_width, x2run);
                    x2_pulses++;
                end
                x2run = 0;
            end
        end
        if (gaps < n_gaps) begin
            flag_failure($sformatf("only %0d sync periods seen, %0d wanted", gaps, n_gaps));
        end
        if (x2_pulses < n_gaps) begin
            flag_failure($sformatf("only %0d sync_x2 pulses seen, %0d wanted",
                                   x2_pulses, n_gaps));
        end
    endtask

    task automatic check_wait(input logic want);
        int n;
        int n_high;
        n      = 0;
        n_high = 0;
        while (llrf_sync_done !== want && n < wait_limit) begin
            @(posedge clk);
            n++;
        end
        if (llrf_sync_done !== want) begin
            flag_failure($sformatf("llrf_sync_done did not reach %0d within %0d cycles",
                                   want, wait_limit));
        end else begin
            checks++;
            // DDS clock output runs at half rate only once start-up is done
            for (int k = 0; k < clk_window; k++) begin
                @(posedge clk);
                if (dds_clk_out !== 1'b0) begin
                    n_high++;
                end
            end
            check_eq("dds_clk_out high cycles", want ? clk_window / 2 : 0, n_high);
        end
    endtask

    always @(posedge clk) begin
        if (go) begin
            busy_q  = 1'b1;
            test_ok = 1'b1;
            tests++;
            case (op)
                op_read:   check_read(expv);
                op_event:  check_event(expv);
                op_period: check_period(int'(data), int'(expv));
                op_wait:   check_wait(expv[0]);
                default: ;
            endcase
            $display("Test %0d %s 0x%0h: %s", tests, op_name(op), sel,
                     test_ok ? "ok" : "mismatch");
            busy_q = 1'b0;
        end
    end

    always @(posedge all_done) begin
        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    end

endmodule

// File: test/tb_scc.sv
//----------------------------
// Testbench top, runs the test list in test/scc_tests.txt against the sync block
// Inputs change on the falling edge, scc_checker compares on the rising edge
//----------------------------
`timescale 1ns/100ps

module tb_scc;
    import scc_event_pkg::*;

    localparam int clk_period      = 100;
    localparam int reset_cycles    = 10;
    localparam int pulse_width     = 2;
    localparam int max_tests       = 64;
    localparam int cycles_per_test = 200;

    localparam logic [3:0] op_write = 4'd1;
    localparam logic [3:0] op_read  = 4'd2;
    localparam logic [3:0] op_event = 4'd3;
    localparam logic [3:0] op_level = 4'd4;
    localparam logic [3:0] op_idle  = 4'd7;

    logic                clk = 1'b0;
    logic                aresetn;
    logic                reg_wr;
    logic                reg_rd;
    logic [7:0]          reg_addr;
    logic [31:0]         reg_wdata;
    logic [31:0]         reg_rdata;
    logic                reg_rvalid;
    logic [7:0]          ev;
    logic                afe_init_done;
    logic                evr_link_ok;
    logic                dc_coarse_done;
    logic                llrf_sync_done;
    logic                sync;
    logic                sync_x2;
    logic                align_x2;
    logic [ev_chans-1:0] test_out;
    logic                dds_clk_out;

    // Four words per test line: op, sel, data, expected
    logic [31:0] test_mem [4*max_tests];
    logic [3:0]  cur_op;
    logic [7:0]  cur_sel;
    logic [31:0] cur_data;
    logic [31:0] cur_exp;
    logic        go = 1'b0;
    logic        busy;
    logic        all_done = 1'b0;
    logic        loaded = 1'b0;
    int          err_cnt;
    int          n_tests = 0;

    always #(clk_period / 2) clk = ~clk;

    scc_top #(
        .sync_prd_def(64),
        .pulse_width (pulse_width)
    ) dut_i (
        .clk            (clk),
        .aresetn        (aresetn),
        .reg_wr         (reg_wr),
        .reg_rd         (reg_rd),
        .reg_addr       (reg_addr),
        .reg_wdata      (reg_wdata),
        .reg_rdata      (reg_rdata),
        .reg_rvalid     (reg_rvalid),
        .ev             (ev),
        .afe_init_done  (afe_init_done),
        .evr_link_ok    (evr_link_ok),
        .dc_coarse_done (dc_coarse_done),
        .llrf_sync_done (llrf_sync_done),
        .sync           (sync),
        .sync_x2        (sync_x2),
        .align_x2       (align_x2),
        .test_out       (test_out),
        .dds_clk_out    (dds_clk_out)
    );

    scc_checker #(
        .pulse_width(pulse_width)
    ) chk_i (
        .clk            (clk),
        .go             (go),
        .op             (cur_op),
        .sel            (cur_sel),
        .data           (cur_data),
        .expv           (cur_exp),
        .all_done       (all_done),
        .reg_rvalid     (reg_rvalid),
        .reg_rdata      (reg_rdata),
        .llrf_sync_done (llrf_sync_done),
        .sync           (sync),
        .sync_x2        (sync_x2),
        .align_x2       (align_x2),
        .test_out       (test_out),
        .dds_clk_out    (dds_clk_out),
        .busy           (busy),
        .err_cnt        (err_cnt)
    );

    function automatic bit valid_op(input logic [31:0] word);
        return word >= 32'd1 && word <= 32'd7;
    endfunction

    // Called on a falling edge, returns on a falling edge
    task automatic apply_test(input int idx);
        cur_op   = test_mem[4*idx][3:0];
        cur_sel  = test_mem[4*idx+1][7:0];
        cur_data = test_mem[4*idx+2];
        cur_exp  = test_mem[4*idx+3];
        go       = 1'b1;
        case (cur_op)
            op_write: begin
                reg_wr    = 1'b1;
                reg_addr  = cur_sel;
                reg_wdata = cur_data;
            end
            op_read: begin
                reg_rd   = 1'b1;
                reg_addr = cur_sel;
            end
            op_event: ev = cur_sel;
            op_level: begin
                case (cur_sel)
                    8'd0:    afe_init_done  = cur_data[0];
                    8'd1:    evr_link_ok    = cur_data[0];
                    default: dc_coarse_done = cur_data[0];
                endcase
            end
            default: ;
        endcase
        @(negedge clk);
        go     = 1'b0;
        reg_wr = 1'b0;
        reg_rd = 1'b0;
        ev     = '0;
        if (cur_op == op_idle) begin
            repeat (cur_data) @(negedge clk);
        end
        while (busy) begin
            @(negedge clk);
        end
    endtask

    initial begin
        aresetn        = 1'b0;
        reg_wr         = 1'b0;
        reg_rd         = 1'b0;
        reg_addr       = '0;
        reg_wdata      = '0;
        ev             = '0;
        afe_init_done  = 1'b0;
        evr_link_ok    = 1'b0;
        dc_coarse_done = 1'b0;
        $readmemh("test/scc_tests.txt", test_mem);
        // List ends at the first op of 0
        while (n_tests < max_tests && valid_op(test_mem[4*n_tests])) begin
            n_tests++;
        end
        loaded = 1'b1;
        repeat (reset_cycles) @(negedge clk);
        aresetn = 1'b1;
        for (int t = 0; t < n_tests; t++) begin
            @(negedge clk);
            apply_test(t);
        end
        all_done = 1'b1;
        #1;
        if (n_tests > 0 && err_cnt == 0) begin
            $display("All checks passed");
        end else begin
            if (n_tests == 0) begin
                $display("No test lines were read from test/scc_tests.txt");
            end
            $display("Checks failed");
        end
        $finish;
    end

    // Watchdog sized from the test list
    initial begin
        wait (loaded);
        #((reset_cycles + n_tests * cycles_per_test) * clk_period);
        $display("Timeout: the test list did not finish within %0d cycles",
                 reset_cycles + n_tests * cycles_per_test);
        $display("Checks failed");
        $finish;
    end

endmodule

// File: test/scc_tests.txt
// Columns in hex: op sel data expected
// op 1 write, 2 read, 3 event, 4 level, 5 period, 6 wait, 7 idle, 0 end of list
// sel is the register address, the event code, or the level input (0 afe, 1 link, 2 coarse)
// Register readback
1 10 5a 0
2 10 0 5a
1 20 33 0
2 20 0 33
1 2c 42 0
2 2c 0 42
1 14 a 0
1 14 0 0
2 14 0 a
1 08 7 0
1 0c 1 0
2 04 0 6
// Manual mode, period 10, three gaps
5 0 a 3
// Event pulses, expected is the output mask
3 33 0 1
3 42 0 4
3 0 0 0
3 77 0 0
// Sticky status in automatic mode
1 04 0 0
4 0 1 0
4 2 1 0
4 0 0 0
4 0 1 0
4 2 0 0
4 2 1 0
2 00 0 30
1 00 20 0
2 00 0 20
1 00 0 0
2 00 0 0
// Automatic start-up, then link loss
4 1 1 0
7 0 5 0
3 5a 0 0
6 0 0 1
2 00 0 7
4 1 0 0
6 0 0 0
2 00 0 8
0 0 0 0

// File: flist.f
design/scc_regs_pkg.sv
design/scc_event_pkg.sv
design/scc_reg_decode.sv
design/scc_event_match.sv
design/scc_sync_engine.sv
design/scc_pulse_out.sv
design/scc_top.sv
test/scc_checker.sv
test/tb_scc.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_scc -f flist.f -o tb_scc
out=$(./obj_dir/tb_scc)
echo "$out"
if echo "$out" | grep -q "^All checks passed$"; then
    exit 0
else
    exit 1
fi
